//--- branch_unit.f
+incdir+test
logic/branch_pkg.sv
logic/branch_decode.sv
logic/reg_file.sv
logic/branch_target.sv
logic/branch_compare.sv
logic/branch_unit.sv
test/branch_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the branch unit testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module branch_unit_tb -f branch_unit.f \
    && ./obj_dir/Vbranch_unit_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no verdict found in sim.log"; exit 1; }
exit 0

//--- test/branch_model.svh
// reference model giving the expected valid, flushes and target of one instruction
`ifndef BRANCH_MODEL_SVH
`define BRANCH_MODEL_SVH

function automatic void predict_branch(
    input  logic                              valid,
    input  logic [branch_pkg::data_width-1:0] instr,
    input  logic [branch_pkg::data_width-1:0] pc,
    input  logic [branch_pkg::data_width-1:0] image [branch_pkg::reg_count],
    output logic                              exp_valid,
    output logic                              exp_flush,
    output logic                              exp_ds_flush,
    output logic [branch_pkg::data_width-1:0] exp_target
);
    logic signed [31:0] rs_val;
    logic signed [31:0] rt_val;
    logic [31:0]        seq_pc;
    logic [31:0]        rel_pc;
    logic               cond;
    logic               likely;

    rs_val = image[instr[25:21]];
    rt_val = image[instr[20:16]];
    seq_pc = pc + 32'd4;
    // word offset counted from the delay slot
    rel_pc = seq_pc + ({{16{instr[15]}}, instr[15:0]} << 2);
    cond       = 1'b0;
    likely     = 1'b0;
    exp_target = '0;
    case (instr[31:26])
        branch_pkg::op_beq, branch_pkg::op_beql: begin
            cond       = (rs_val == rt_val);
            // likely opcodes sit 16 above the base ones
            likely     = instr[30];
            exp_target = rel_pc;
        end
        branch_pkg::op_bne, branch_pkg::op_bnel: begin
            cond       = (rs_val != rt_val);
            likely     = instr[30];
            exp_target = rel_pc;
        end
        branch_pkg::op_blez, branch_pkg::op_blezl: begin
            cond       = (rs_val <= 0);
            likely     = instr[30];
            exp_target = rel_pc;
        end
        branch_pkg::op_bgtz, branch_pkg::op_bgtzl: begin
            cond       = (rs_val > 0);
            likely     = instr[30];
            exp_target = rel_pc;
        end
        branch_pkg::op_regimm: begin
            // only rt codes 0 to 3 where bit 0 picks bgez and bit 1 likely
            if (instr[20:18] == 3'd0) begin
                cond       = instr[16] ? (rs_val >= 0) : (rs_val < 0);
                likely     = instr[17];
                exp_target = rel_pc;
            end
        end
        branch_pkg::op_j: begin
            cond       = 1'b1;
            exp_target = {seq_pc[31:28], instr[25:0], 2'b00};
        end
        branch_pkg::op_special: begin
            if (instr[5:0] == branch_pkg::funct_jr) begin
                cond       = 1'b1;
                exp_target = rs_val;
            end
        end
        default: begin
            cond = 1'b0;
        end
    endcase
    exp_valid    = valid;
    exp_flush    = valid && cond;
    exp_ds_flush = valid && likely && !cond;
endfunction

`endif

//--- test/branch_unit_tb.sv
// testbench for the branch resolution unit with a reference model and queued compares
`timescale 1ns/1ps

module branch_unit_tb;

    localparam int clk_period     = 100;
    localparam int load_writes    = 32;
    // directed slots incl. idles and the rewrite
    localparam int n_directed     = 37;
    localparam int n_random       = 200;
    localparam int timeout_cycles = load_writes + n_directed + n_random + 20;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] in_instr;
    logic [31:0] in_pc;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;
    logic        out_valid;
    logic        branch_flush;
    logic        delayslot_flush;
    logic [31:0] branch_target;

    // shadow register image and expectation queue
    logic [31:0] shadow [branch_pkg::reg_count];
    logic [34:0] pending [$];
    logic [34:0] exp_word;
    logic [31:0] held_target;
    logic        p_valid;
    logic        p_flush;
    logic        p_ds;
    logic [31:0] p_target;
    logic [31:0] fetch_pc;
    int          valid_errs;
    int          flush_errs;
    int          ds_errs;
    int          target_errs;

    `include "branch_model.svh"

    branch_unit DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_instr        (in_instr),
        .in_pc           (in_pc),
        .wr_en           (wr_en),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .out_valid       (out_valid),
        .branch_flush    (branch_flush),
        .delayslot_flush (delayslot_flush),
        .branch_target   (branch_target)
    );

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // instruction word builders
    function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encode_jr(input logic [4:0] rs);
        return {6'd0, rs, 15'd0, branch_pkg::funct_jr};
    endfunction

    task automatic drive_slot(input logic valid, input logic [31:0] instr,
                              input logic [31:0] pc);
        @(posedge clk);
        in_valid <= valid;
        in_instr <= instr;
        in_pc    <= pc;
        wr_en    <= 1'b0;
    endtask

    // valid instruction at the running fetch pc
    task automatic issue_instr(input logic [31:0] instr);
        drive_slot(1'b1, instr, fetch_pc);
        fetch_pc = fetch_pc + 32'd4;
    endtask

    task automatic load_reg(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        in_valid <= 1'b0;
        wr_en    <= 1'b1;
        wr_addr  <= addr;
        wr_data  <= data;
    endtask

    // compare process checking outputs two edges after sampling
    always @(negedge clk) begin
        if (pending.size() == 2) begin
            exp_word = pending.pop_front();
            assert (out_valid === exp_word[34]) else begin
                $display("ERROR at %0t: out_valid %b, expected %b", $time, out_valid,
                         exp_word[34]);
                valid_errs++;
            end
            assert (branch_flush === exp_word[33]) else begin
                $display("ERROR at %0t: branch_flush %b, expected %b", $time, branch_flush,
                         exp_word[33]);
                flush_errs++;
            end
            assert (delayslot_flush === exp_word[32]) else begin
                $display("ERROR at %0t: delayslot_flush %b, expected %b", $time,
                         delayslot_flush, exp_word[32]);
                ds_errs++;
            end
            // target only moves on valid results
            if (exp_word[34]) begin
                held_target = exp_word[31:0];
            end
            assert (branch_target === held_target) else begin
                $display("ERROR at %0t: branch_target %h, expected %h", $time, branch_target,
                         held_target);
                target_errs++;
            end
        end
        predict_branch(in_valid, in_instr, in_pc, shadow, p_valid, p_flush, p_ds, p_target);
        pending.push_back({p_valid, p_flush, p_ds, p_target});
        // write lands after this slot's read
        if (wr_en && (wr_addr != 5'd0)) begin
            shadow[wr_addr] = wr_data;
        end
    end

    // watchdog
    initial begin
        #(timeout_cycles * clk_period);
        $display("run timed out after %0d clock periods without finishing", timeout_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] word;
        logic [31:0] instr;
        logic [31:0] slot_pc;
        logic        slot_valid;
        logic [4:0]  sign_regs [4];
        int          kind;

        word = $urandom(57);
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_instr    = '0;
        in_pc       = '0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        held_target = '0;
        fetch_pc    = 32'h0040_0000;
        for (int r = 0; r < branch_pkg::reg_count; r++) begin
            shadow[r] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        drive_slot(1'b0, '0, '0);

        // r1 r2 equal, r4 most negative, r5 negative, r6 zero, r7 positive
        for (int r = 0; r < branch_pkg::reg_count; r++) begin
            word = $urandom;
            case (r)
                1, 2:    word = 32'd5;
                3:       word = 32'd7;
                4:       word = 32'h8000_0000;
                5:       word = 32'hFFFF_FFFF;
                6:       word = 32'd0;
                7:       word = 32'd1;
                default: word = word;
            endcase
            load_reg(5'(r), word);
        end

        // equality branches with r0 as operand and a backward offset
        issue_instr(encode_itype(branch_pkg::op_beq, 5'd1, 5'd2, 16'h0010));
        issue_instr(encode_itype(branch_pkg::op_beq, 5'd1, 5'd3, 16'hFFF0));
        issue_instr(encode_itype(branch_pkg::op_bne, 5'd1, 5'd3, 16'h0020));
        issue_instr(encode_itype(branch_pkg::op_bne, 5'd1, 5'd2, 16'h8000));
        issue_instr(encode_itype(branch_pkg::op_beq, 5'd0, 5'd6, 16'h0004));
        issue_instr(encode_itype(branch_pkg::op_bne, 5'd0, 5'd7, 16'h7FFF));

        // sign tests over zero, positive, negative and most negative
        sign_regs = '{5'd6, 5'd7, 5'd5, 5'd4};
        for (int i = 0; i < 4; i++) begin
            issue_instr(encode_itype(branch_pkg::op_regimm, sign_regs[i], branch_pkg::rt_bgez,
                                     16'h0040));
            issue_instr(encode_itype(branch_pkg::op_bgtz, sign_regs[i], 5'd0, 16'hFF00));
            issue_instr(encode_itype(branch_pkg::op_blez, sign_regs[i], 5'd0, 16'h0100));
            issue_instr(encode_itype(branch_pkg::op_regimm, sign_regs[i], branch_pkg::rt_bltz,
                                     16'hFFFC));
        end

        // likely forms both ways
        issue_instr(encode_itype(branch_pkg::op_beql, 5'd1, 5'd2, 16'h0008));
        issue_instr(encode_itype(branch_pkg::op_beql, 5'd1, 5'd3, 16'h0008));
        issue_instr(encode_itype(branch_pkg::op_bnel, 5'd1, 5'd3, 16'hFFF8));
        issue_instr(encode_itype(branch_pkg::op_bnel, 5'd1, 5'd2, 16'hFFF8));
        issue_instr(encode_itype(branch_pkg::op_blezl, 5'd7, 5'd0, 16'h0030));
        issue_instr(encode_itype(branch_pkg::op_bgtzl, 5'd7, 5'd0, 16'h0030));
        issue_instr(encode_itype(branch_pkg::op_regimm, 5'd7, branch_pkg::rt_bltzl, 16'h0002));
        issue_instr(encode_itype(branch_pkg::op_regimm, 5'd5, branch_pkg::rt_bgezl, 16'h0002));

        // jumps across a 256 MB region boundary
        fetch_pc = 32'h0FFF_FFF8;
        issue_instr({branch_pkg::op_j, 26'h3AB_CDEF});
        issue_instr({branch_pkg::op_j, 26'h000_0123});
        issue_instr(encode_jr(5'd3));
        load_reg(5'd3, 32'h1234_5678);
        drive_slot(1'b0, '0, '0);
        drive_slot(1'b0, '0, '0);
        issue_instr(encode_jr(5'd3));

        // random back-to-back stream
        for (int n = 0; n < n_random; n++) begin
            word       = $urandom;
            slot_pc    = $urandom;
            slot_pc    = {slot_pc[31:2], 2'b00};
            slot_valid = ($urandom_range(3, 0) != 0);
            kind       = $urandom_range(9, 0);
            case (kind)
                0: instr = encode_itype(word[10] ? branch_pkg::op_beql : branch_pkg::op_beq,
                                        word[4:0], word[9:5], word[31:16]);
                1: instr = encode_itype(word[10] ? branch_pkg::op_bnel : branch_pkg::op_bne,
                                        word[4:0], word[9:5], word[31:16]);
                2: instr = encode_itype(branch_pkg::op_blez, word[4:0], 5'd0, word[31:16]);
                3: instr = encode_itype(branch_pkg::op_bgtzl, word[4:0], 5'd0, word[31:16]);
                4: instr = encode_itype(branch_pkg::op_regimm, word[4:0], {3'd0, word[6:5]},
                                        word[31:16]);
                5: instr = {branch_pkg::op_j, word[25:0]};
                6: instr = encode_jr(word[4:0]);
                // addiu and add never branch
                7: instr = encode_itype(6'd9, word[4:0], word[9:5], word[31:16]);
                8: instr = {6'd0, word[4:0], word[9:5], word[14:10], 5'd0, 6'h20};
                default: instr = word;
            endcase
            drive_slot(slot_valid, instr, slot_pc);
        end

        // drain the pipeline
        repeat (4) drive_slot(1'b0, '0, '0);
        @(posedge clk);
        $display("errors: out_valid %0d, branch_flush %0d, delayslot_flush %0d, target %0d",
                 valid_errs, flush_errs, ds_errs, target_errs);
        if ((valid_errs + flush_errs + ds_errs + target_errs) == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- logic/branch_unit.sv
// branch resolution top joining decoder, register file, target unit and comparator
`timescale 1ns/1ps

module branch_unit (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    in_valid,
    input  logic [branch_pkg::data_width-1:0]       in_instr,
    input  logic [branch_pkg::data_width-1:0]       in_pc,
    input  logic                                    wr_en,
    input  logic [branch_pkg::reg_addr_width-1:0]   wr_addr,
    input  logic [branch_pkg::data_width-1:0]       wr_data,
    output logic                                    out_valid,
    output logic                                    branch_flush,
    output logic                                    delayslot_flush,
    output logic [branch_pkg::data_width-1:0]       branch_target
);

    // id-stage wires
    logic [branch_pkg::reg_addr_width-1:0] rs_addr;
    logic [branch_pkg::reg_addr_width-1:0] rt_addr;
    branch_pkg::branch_code_e              id_code;

    // ex-stage wires
    logic                                  ex_valid;
    branch_pkg::branch_code_e              ex_code;
    logic                                  ex_likely;
    logic [branch_pkg::data_width-1:0]     rs_data;
    logic [branch_pkg::data_width-1:0]     rt_data;
    logic [branch_pkg::data_width-1:0]     ex_target;

    // decode and id/ex staging
    branch_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .id_code   (id_code),
        .ex_valid  (ex_valid),
        .ex_code   (ex_code),
        .ex_likely (ex_likely)
    );

    // operand fetch
    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // target generation
    branch_target u_target (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_pc     (in_pc),
        .in_instr  (in_instr),
        .id_code   (id_code),
        .rs_data   (rs_data),
        .ex_target (ex_target)
    );

    // resolution and output register
    branch_compare u_compare (
        .clk             (clk),
        .rst_n           (rst_n),
        .ex_valid        (ex_valid),
        .ex_code         (ex_code),
        .ex_likely       (ex_likely),
        .rs_data         (rs_data),
        .rt_data         (rt_data),
        .ex_target       (ex_target),
        .out_valid       (out_valid),
        .branch_flush    (branch_flush),
        .delayslot_flush (delayslot_flush),
        .branch_target   (branch_target)
    );

endmodule

//--- logic/branch_compare.sv
// branch comparator resolving taken and registering flushes and target
`timescale 1ns/1ps

module branch_compare (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                ex_valid,
    input  branch_pkg::branch_code_e            ex_code,
    input  logic                                ex_likely,
    input  logic [branch_pkg::data_width-1:0]   rs_data,
    input  logic [branch_pkg::data_width-1:0]   rt_data,
    input  logic [branch_pkg::data_width-1:0]   ex_target,
    output logic                                out_valid,
    output logic                                branch_flush,
    output logic                                delayslot_flush,
    output logic [branch_pkg::data_width-1:0]   branch_target
);

    // shared comparison terms
    logic ops_equal;
    logic rs_zero;
    logic rs_neg;
    logic taken;

    assign ops_equal = (rs_data == rt_data);
    assign rs_zero   = (rs_data == '0);
    // sign bit of rs
    assign rs_neg    = rs_data[branch_pkg::data_width-1];

    // condition select
    always_comb begin
        if (!ex_valid) begin
            taken = 1'b0;
        end else begin
            case (ex_code)
                branch_pkg::br_beq:  taken = ops_equal;
                branch_pkg::br_bne:  taken = !ops_equal;
                branch_pkg::br_bgez: taken = !rs_neg;
                // strictly positive
                branch_pkg::br_bgtz: taken = !rs_neg && !rs_zero;
                branch_pkg::br_blez: taken = rs_neg || rs_zero;
                branch_pkg::br_bltz: taken = rs_neg;
                // unconditional transfers
                branch_pkg::br_jr:   taken = 1'b1;
                branch_pkg::br_j:    taken = 1'b1;
                default:             taken = 1'b0;
            endcase
        end
    end

    // output stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid       <= 1'b0;
            branch_flush    <= 1'b0;
            delayslot_flush <= 1'b0;
            branch_target   <= '0;
        end else begin
            out_valid       <= ex_valid;
            // taken always refetches
            branch_flush    <= taken;
            // untaken likely kills its delay slot
            delayslot_flush <= ex_valid && ex_likely && !taken;
            // target held over bubbles
            if (ex_valid) begin
                branch_target <= ex_target;
            end
        end
    end

endmodule

//--- logic/branch_target.sv
// branch target unit forming pc-relative, jump-region and register targets
`timescale 1ns/1ps

module branch_target (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [branch_pkg::data_width-1:0]   in_pc,
    input  logic [branch_pkg::data_width-1:0]   in_instr,
    input  branch_pkg::branch_code_e            id_code,
    input  logic [branch_pkg::data_width-1:0]   rs_data,
    output logic [branch_pkg::data_width-1:0]   ex_target
);

    // id-stage candidates
    logic [branch_pkg::data_width-1:0] pc_plus4;
    logic [branch_pkg::data_width-1:0] br_offset;
    logic [branch_pkg::data_width-1:0] rel_target;
    logic [branch_pkg::data_width-1:0] jmp_target;

    // ex-stage state
    logic [branch_pkg::data_width-1:0] cand_target;
    logic                              reg_sel;

    assign pc_plus4   = in_pc + 32'd4;
    // sign-extended word offset
    assign br_offset  = {{14{in_instr[15]}}, in_instr[15:0], 2'b00};
    assign rel_target = pc_plus4 + br_offset;
    // region of the delay slot joined with the 26-bit index
    assign jmp_target = {pc_plus4[31:28], in_instr[25:0], 2'b00};

    // candidate chosen by the decoded code
    always_ff @(posedge clk) begin
        case (id_code)
            branch_pkg::br_none: cand_target <= '0;
            branch_pkg::br_j:    cand_target <= jmp_target;
            // jr value arrives later from the register file
            branch_pkg::br_jr:   cand_target <= '0;
            default:             cand_target <= rel_target;
        endcase
    end

    // register-target flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_sel <= 1'b0;
        end else begin
            reg_sel <= (id_code == branch_pkg::br_jr);
        end
    end

    // ex-stage select
    // rs_data is already the registered read for this instruction
    assign ex_target = reg_sel ? rs_data : cand_target;

endmodule

//--- logic/reg_file.sv
// register file with one write port and two registered read ports
`timescale 1ns/1ps

module reg_file (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    wr_en,
    input  logic [branch_pkg::reg_addr_width-1:0]   wr_addr,
    input  logic [branch_pkg::data_width-1:0]       wr_data,
    input  logic [branch_pkg::reg_addr_width-1:0]   rs_addr,
    input  logic [branch_pkg::reg_addr_width-1:0]   rt_addr,
    output logic [branch_pkg::data_width-1:0]       rs_data,
    output logic [branch_pkg::data_width-1:0]       rt_data
);

    // architectural registers
    logic [branch_pkg::data_width-1:0] regs [branch_pkg::reg_count];

    // write port
    // register 0 stays hardwired to zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < branch_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // read ports sample the array before this edge's write lands
    // so a same-edge read returns the old contents
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs_data <= '0;
            rt_data <= '0;
        end else begin
            if (rs_addr == '0) begin
                rs_data <= '0;
            end else begin
                rs_data <= regs[rs_addr];
            end
            // same zero rule on the rt port
            if (rt_addr == '0) begin
                rt_data <= '0;
            end else begin
                rt_data <= regs[rt_addr];
            end
        end
    end

endmodule

//--- logic/branch_decode.sv
// branch decoder classifying the id-stage instruction and staging it into execute
`timescale 1ns/1ps

module branch_decode (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    in_valid,
    input  logic [branch_pkg::data_width-1:0]       in_instr,
    output logic [branch_pkg::reg_addr_width-1:0]   rs_addr,
    output logic [branch_pkg::reg_addr_width-1:0]   rt_addr,
    output branch_pkg::branch_code_e                id_code,
    output logic                                    ex_valid,
    output branch_pkg::branch_code_e                ex_code,
    output logic                                    ex_likely
);

    // instruction fields
    branch_pkg::mips_op_e   opcode;
    branch_pkg::regimm_rt_e regimm_rt;
    logic [5:0]             funct;
    logic                   id_likely;

    assign opcode    = branch_pkg::mips_op_e'(in_instr[31:26]);
    assign regimm_rt = branch_pkg::regimm_rt_e'(in_instr[20:16]);
    assign funct     = in_instr[5:0];

    // register file read addresses straight from the word
    assign rs_addr = in_instr[25:21];
    assign rt_addr = in_instr[20:16];

    // classify into a branch code plus likely flag
    always_comb begin
        id_code   = branch_pkg::br_none;
        id_likely = 1'b0;
        case (opcode)
            branch_pkg::op_special: begin
                // only jr among special ops
                if (funct == branch_pkg::funct_jr) begin
                    id_code = branch_pkg::br_jr;
                end
            end
            branch_pkg::op_regimm: begin
                case (regimm_rt)
                    branch_pkg::rt_bltz: begin
                        id_code = branch_pkg::br_bltz;
                    end
                    branch_pkg::rt_bgez: begin
                        id_code = branch_pkg::br_bgez;
                    end
                    branch_pkg::rt_bltzl: begin
                        id_code   = branch_pkg::br_bltz;
                        id_likely = 1'b1;
                    end
                    branch_pkg::rt_bgezl: begin
                        id_code   = branch_pkg::br_bgez;
                        id_likely = 1'b1;
                    end
                    default: begin
                        id_code = branch_pkg::br_none;
                    end
                endcase
            end
            branch_pkg::op_j: begin
                id_code = branch_pkg::br_j;
            end
            branch_pkg::op_beq: begin
                id_code = branch_pkg::br_beq;
            end
            branch_pkg::op_bne: begin
                id_code = branch_pkg::br_bne;
            end
            branch_pkg::op_blez: begin
                id_code = branch_pkg::br_blez;
            end
            branch_pkg::op_bgtz: begin
                id_code = branch_pkg::br_bgtz;
            end
            // likely variants map onto the base code
            branch_pkg::op_beql: begin
                id_code   = branch_pkg::br_beq;
                id_likely = 1'b1;
            end
            branch_pkg::op_bnel: begin
                id_code   = branch_pkg::br_bne;
                id_likely = 1'b1;
            end
            branch_pkg::op_blezl: begin
                id_code   = branch_pkg::br_blez;
                id_likely = 1'b1;
            end
            branch_pkg::op_bgtzl: begin
                id_code   = branch_pkg::br_bgtz;
                id_likely = 1'b1;
            end
            default: begin
                id_code = branch_pkg::br_none;
            end
        endcase
    end

    // id to ex pipeline register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            ex_code   <= branch_pkg::br_none;
            ex_likely <= 1'b0;
        end else begin
            // bubble when no instruction arrives
            ex_valid  <= in_valid;
            ex_code   <= id_code;
            ex_likely <= id_likely;
        end
    end

endmodule

//--- logic/branch_pkg.sv
// branch package with datapath widths, register count and decode enums
package branch_pkg;

    // datapath width for registers, operands, pc and targets
    localparam int data_width = 32;

    // register index width
    localparam int reg_addr_width = 5;

    // number of architectural registers
    localparam int reg_count = 32;

    // primary opcode field in bits 31 to 26
    typedef enum logic [5:0] {
        op_special = 6'd0,
        op_regimm  = 6'd1,
        op_j       = 6'd2,
        op_beq     = 6'd4,
        op_bne     = 6'd5,
        op_blez    = 6'd6,
        op_bgtz    = 6'd7,
        op_beql    = 6'd20,
        op_bnel    = 6'd21,
        op_blezl   = 6'd22,
        op_bgtzl   = 6'd23
    } mips_op_e;

    // regimm sub-op carried in the rt field
    typedef enum logic [4:0] {
        rt_bltz  = 5'd0,
        rt_bgez  = 5'd1,
        rt_bltzl = 5'd2,
        rt_bgezl = 5'd3
    } regimm_rt_e;

    // special funct for jump register
    localparam logic [5:0] funct_jr = 6'd8;

    // resolved control transfer kind
    // likely forms share the base code
    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_bgez,
        br_bgtz,
        br_blez,
        br_bltz,
        br_jr,
        br_j
    } branch_code_e;

endpackage
